// ==== Bender.yml ====
package:
  name: audio_mix

sources:
  - files:
      - hw/uio_pkg.sv
      - hw/audio_pkg.sv
      - hw/uio_cmd_decoder.sv
      - hw/audio_channel_mix.sv
      - hw/audio_mix_top.sv
  - target: test
    files:
      - verification/audio_mix_assert.sv
      - verification/tb_audio_mix.sv

// ==== hw/audio_channel_mix.sv ====
`default_nettype none

module audio_channel_mix (
	input  logic                  clk,
	input  logic                  resetd,
	input  audio_pkg::audio_fmt_t i_fmt,
	input  audio_pkg::att_t       i_att,
	input  audio_pkg::sample_t    i_core,
	input  audio_pkg::sample_t    i_host,
	input  audio_pkg::sample_t    i_pre,
	output audio_pkg::sample_t    o_pre,
	output audio_pkg::sample_t    o_audio
);

	import audio_pkg::*;

	//////////////////////////////////////////////////
	// Core sample deglitch
	//////////////////////////////////////////////////

	sample_t dly1;
	sample_t dly2;
	sample_t dly3;
	sample_t hold;

	// Three-deep delay, the hold register only follows a stable value
	always_ff @(posedge clk) begin
		if (resetd) begin
			dly1 <= '0;
			dly2 <= '0;
			dly3 <= '0;
			hold <= '0;
		end else begin
			dly1 <= i_core;
			dly2 <= dly1;
			dly3 <= dly2;
			if (dly2 == dly3) begin
				hold <= dly2;
			end
		end
	end

	//////////////////////////////////////////////////
	// Conversion and sum
	//////////////////////////////////////////////////

	acc_t conv_d;
	acc_t conv_q;
	acc_t host_ext;
	acc_t sum_q;
	sample_t pre_q;

	// Unsigned samples are halved so they fit as positive values
	assign conv_d = i_fmt.is_signed ? acc_t'({hold[15], hold}) : acc_t'({2'b00, hold[15:1]});

	assign host_ext = acc_t'({i_host[15], i_host});

	always_ff @(posedge clk) begin
		if (resetd) begin
			conv_q <= '0;
			sum_q  <= '0;
			pre_q  <= '0;
		end else begin
			conv_q <= conv_d;
			sum_q  <= conv_q + host_ext;
			// Half of the sum goes to the other channel
			pre_q  <= sum_q[16:1];
		end
	end

	assign o_pre = pre_q;

	//////////////////////////////////////////////////
	// Crossfeed, attenuation and clamp
	//////////////////////////////////////////////////

	acc_t pre_ext;
	acc_t xfeed_d;
	acc_t xfeed_q;
	acc_t att_d;
	acc_t att_q;
	sample_t clamp_d;
	sample_t out_q;

	assign pre_ext = acc_t'({i_pre[15], i_pre});

	always_comb begin
		case (i_fmt.mix)
			2'd1:    xfeed_d = sum_q - (sum_q >>> 3) + (pre_ext >>> 2);
			2'd2:    xfeed_d = sum_q - (sum_q >>> 2) + (pre_ext >>> 1);
			2'd3:    xfeed_d = (sum_q >>> 1) + pre_ext;
			default: xfeed_d = sum_q;
		endcase
	end

	// Mute wins over any shift
	assign att_d = i_att[4] ? acc_t'(0) : (xfeed_q >>> i_att[3:0]);

	// Saturate when the guard bit and bit 15 disagree
	always_comb begin
		if (att_q[16] != att_q[15]) begin
			clamp_d = {att_q[16], {15{att_q[15]}}};
		end else begin
			clamp_d = att_q[15:0];
		end
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			xfeed_q <= '0;
			att_q   <= '0;
			out_q   <= '0;
		end else begin
			xfeed_q <= xfeed_d;
			att_q   <= att_d;
			out_q   <= clamp_d;
		end
	end

	assign o_audio = out_q;

endmodule

`default_nettype wire

// ==== hw/audio_mix_top.sv ====
`default_nettype none

module audio_mix_top (
	input  logic                  clk,
	input  logic                  resetd,
	input  uio_pkg::uio_bus_t     i_uio,
	input  audio_pkg::audio_fmt_t i_fmt,
	input  audio_pkg::sample_t    i_core_l,
	input  audio_pkg::sample_t    i_core_r,
	input  audio_pkg::sample_t    i_host_l,
	input  audio_pkg::sample_t    i_host_r,
	output audio_pkg::sample_t    o_audio_l,
	output audio_pkg::sample_t    o_audio_r
);

	import audio_pkg::*;

	att_t    att;
	sample_t pre_l;
	sample_t pre_r;

	//////////////////////////////////////////////////
	// Host command port
	//////////////////////////////////////////////////

	uio_cmd_decoder cmd0 (
		.clk    (clk),
		.resetd (resetd),
		.i_uio  (i_uio),
		.o_att  (att)
	);

	//////////////////////////////////////////////////
	// Left and right mixers
	//////////////////////////////////////////////////

	// Each channel takes the other one's pre sample as crossfeed
	audio_channel_mix mix_l (
		.clk     (clk),
		.resetd  (resetd),
		.i_fmt   (i_fmt),
		.i_att   (att),
		.i_core  (i_core_l),
		.i_host  (i_host_l),
		.i_pre   (pre_r),
		.o_pre   (pre_l),
		.o_audio (o_audio_l)
	);

	audio_channel_mix mix_r (
		.clk     (clk),
		.resetd  (resetd),
		.i_fmt   (i_fmt),
		.i_att   (att),
		.i_core  (i_core_r),
		.i_host  (i_host_r),
		.i_pre   (pre_l),
		.o_pre   (pre_r),
		.o_audio (o_audio_r)
	);

endmodule

`default_nettype wire

// ==== hw/audio_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////
// Audio sample format and mixer types
//////////////////////////////////////////////////

package audio_pkg;

	// Raw 16-bit sample, core or host PCM
	typedef logic [15:0] sample_t;

	// Working width inside the mixer, one guard bit
	typedef logic signed [16:0] acc_t;

	// Bit 4 mutes, bits 3:0 give the right shift
	typedef logic [4:0] att_t;

	// Crossfeed mode, 0 is no crossfeed
	typedef logic [1:0] mix_t;

	// Core sample format and mix selection
	typedef struct packed {
		logic is_signed;
		mix_t mix;
	} audio_fmt_t;

	// Full volume after reset
	localparam att_t ATT_RESET = 5'd0;

endpackage

`default_nettype wire

// ==== hw/uio_cmd_decoder.sv ====
`default_nettype none

module uio_cmd_decoder (
	input  logic              clk,
	input  logic              resetd,
	input  uio_pkg::uio_bus_t i_uio,
	output audio_pkg::att_t   o_att
);

	import uio_pkg::*;
	import audio_pkg::*;

	//////////////////////////////////////////////////
	// Command FSM
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		WAIT_CMD,
		VOL_DATA,
		IGNORE
	} state_t;

	state_t   state;
	state_t   state_next;
	logic     word_valid;
	uio_cmd_t cmd;
	logic     att_load;
	att_t     att_q;

	// Strobe only counts while the port is selected
	assign word_valid = i_uio.select & i_uio.strobe;

	// First word after select carries the command in its low byte
	assign cmd = i_uio.data[7:0];

	// Only the first data word after a volume command
	assign att_load = word_valid && (state == VOL_DATA);

	always_comb begin
		state_next = state;
		if (!i_uio.select) begin
			state_next = WAIT_CMD;
		end else if (word_valid) begin
			case (state)
				WAIT_CMD: begin
					if (cmd == CMD_VOL_ATT) begin
						state_next = VOL_DATA;
					end else begin
						state_next = IGNORE;
					end
				end
				VOL_DATA: begin
					state_next = IGNORE;
				end
				default: begin
					// Rest of the transfer is dropped until select falls
					state_next = IGNORE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			state <= WAIT_CMD;
		end else begin
			state <= state_next;
		end
	end

	//////////////////////////////////////////////////
	// Attenuation register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			att_q <= ATT_RESET;
		end else if (att_load) begin
			// Mute bit and shift count
			att_q <= i_uio.data[4:0];
		end
	end

	// Shared by both channel mixers
	assign o_att = att_q;

endmodule

`default_nettype wire

// ==== hw/uio_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////
// Host user-I/O command bus
//////////////////////////////////////////////////

package uio_pkg;

	// One data word as sent by the host
	typedef logic [15:0] uio_word_t;

	// Command byte, taken from the low half of the first word
	typedef logic [7:0] uio_cmd_t;

	// Host bus as seen on clk
	// A word is valid when select and strobe are both high
	typedef struct packed {
		logic      select;
		logic      strobe;
		uio_word_t data;
	} uio_bus_t;

	//////////////////////////////////////////////////
	// Command codes
	//////////////////////////////////////////////////

	// Volume attenuation, one data word follows
	localparam uio_cmd_t CMD_VOL_ATT = 8'h26;

endpackage

`default_nettype wire

// ==== verification/audio_mix_assert.sv ====
`default_nettype none

module audio_mix_assert (
	input logic                clk,
	input logic                resetd,
	input uio_pkg::uio_bus_t   i_uio,
	input audio_pkg::att_t     i_att,
	input audio_pkg::sample_t  i_audio_l,
	input audio_pkg::sample_t  i_audio_r
);

	timeunit 1ns;
	timeprecision 1ps;

	logic outs_zero;

	assign outs_zero = (i_audio_l == '0) && (i_audio_r == '0);

	//////////////////////////////////////////////////
	// Command port
	//////////////////////////////////////////////////

	att_after_strobe: assert property (@(posedge clk) disable iff (resetd)
		!$stable(i_att) |-> $past(i_uio.select && i_uio.strobe))
		else $error("attenuation changed without a selected host strobe");

	//////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////

	zero_in_reset: assert property (@(posedge clk) resetd |=> outs_zero)
		else $error("outputs not zero during reset");

	zero_after_reset: assert property (@(posedge clk) $fell(resetd) |=> outs_zero)
		else $error("outputs not zero right after reset");

	// Two cycles through attenuation and clamp stages
	zero_when_muted: assert property (@(posedge clk) disable iff (resetd)
		i_att[4] ##1 i_att[4] |=> outs_zero)
		else $error("outputs not zero while muted");

endmodule

bind audio_mix_top audio_mix_assert asrt0 (
	.clk       (clk),
	.resetd    (resetd),
	.i_uio     (i_uio),
	.i_att     (att),
	.i_audio_l (o_audio_l),
	.i_audio_r (o_audio_r)
);

`default_nettype wire

// ==== verification/tb_audio_mix.sv ====
`default_nettype none

module tb_audio_mix;

	timeunit 1ns;
	timeprecision 1ps;

	import uio_pkg::*;
	import audio_pkg::*;

	localparam int HOLD_CYCLES    = 24;
	localparam int STABLE_CYCLES  = 12;
	localparam int SETTLE_TIMEOUT = 200;

	typedef struct packed {
		sample_t l;
		sample_t r;
	} stereo_t;

	logic       clk;
	logic       resetd;
	uio_bus_t   uio;
	audio_fmt_t fmt;
	sample_t    core_l;
	sample_t    core_r;
	sample_t    host_l;
	sample_t    host_r;
	sample_t    audio_l;
	sample_t    audio_r;

	att_t        att_model;
	logic [31:0] rng_state;
	stereo_t     exp_out;
	logic        cmp_en;
	string       cmp_name;
	string       test_name;
	int          err_count;
	int          check_count;
	int          test_count;
	int          test_err_start;

	audio_mix_top dut0 (
		.clk       (clk),
		.resetd    (resetd),
		.i_uio     (uio),
		.i_fmt     (fmt),
		.i_core_l  (core_l),
		.i_core_r  (core_r),
		.i_host_l  (host_l),
		.i_host_r  (host_r),
		.o_audio_l (audio_l),
		.o_audio_r (audio_r)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	//////////////////////////////////////////////////
	// Random numbers and reference model
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Converted core sample plus host PCM
	function automatic int channel_sum(input audio_fmt_t f, input sample_t core,
		input sample_t host);
		int c;
		int h;
		if (f.is_signed) begin
			c = int'($signed(core));
		end else begin
			c = int'(core >> 1);
		end
		h = int'($signed(host));
		return c + h;
	endfunction

	// Crossfeed, attenuation and saturation of one channel
	function automatic sample_t channel_out(input audio_fmt_t f, input att_t att,
		input int sum, input int other_sum);
		int pre;
		int x;
		int y;
		pre = other_sum >>> 1;
		case (f.mix)
			2'd1:    x = sum - (sum >>> 3) + (pre >>> 2);
			2'd2:    x = sum - (sum >>> 2) + (pre >>> 1);
			2'd3:    x = (sum >>> 1) + pre;
			default: x = sum;
		endcase
		if (att[4]) begin
			y = 0;
		end else begin
			y = x >>> att[3:0];
		end
		if (y > 32767) begin
			y = 32767;
		end else if (y < -32768) begin
			y = -32768;
		end
		return y[15:0];
	endfunction

	function automatic stereo_t ref_mix(input audio_fmt_t f, input att_t att,
		input sample_t c_l, input sample_t c_r, input sample_t h_l, input sample_t h_r);
		stereo_t res;
		int sum_l;
		int sum_r;
		sum_l = channel_sum(f, c_l, h_l);
		sum_r = channel_sum(f, c_r, h_r);
		res.l = channel_out(f, att, sum_l, sum_r);
		res.r = channel_out(f, att, sum_r, sum_l);
		return res;
	endfunction

	//////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		check_count++;
		if (actual !== expected) begin
			err_count++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Outputs are read at the edge, one cycle after the request
	always @(posedge clk) begin
		if (cmp_en) begin
			check_value({cmp_name, " left"}, exp_out.l, audio_l);
			check_value({cmp_name, " right"}, exp_out.r, audio_r);
		end
	end

	task automatic begin_test(input string name);
		test_name      = name;
		test_err_start = err_count;
		test_count++;
	endtask

	task automatic end_test();
		if (err_count == test_err_start) begin
			$display("Test %s: ok", test_name);
		end else begin
			$display("Test %s: %0d errors", test_name, err_count - test_err_start);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic send_word(input uio_word_t w);
		uio.data   = w;
		uio.strobe = 1'b1;
		tick();
		uio.strobe = 1'b0;
		uio.data   = '0;
		tick();
	endtask

	task automatic send_transfer(input uio_cmd_t cmd, input uio_word_t w0,
		input uio_word_t w1, input int n_words);
		uio.select = 1'b1;
		tick();
		send_word({8'h00, cmd});
		if (n_words > 0) begin
			send_word(w0);
		end
		if (n_words > 1) begin
			send_word(w1);
		end
		uio.select = 1'b0;
		tick();
		// Only the first word after a volume command counts
		if (cmd == CMD_VOL_ATT && n_words > 0) begin
			att_model = w0[4:0];
		end
	endtask

	task automatic randomize_samples();
		logic [31:0] r;
		r      = next_rand();
		core_l = r[15:0];
		core_r = r[31:16];
		r      = next_rand();
		host_l = r[15:0];
		host_r = r[31:16];
	endtask

	// Hold inputs until the outputs have stopped moving
	task automatic wait_settled(input string label);
		int      cycles;
		int      stable;
		sample_t last_l;
		sample_t last_r;
		cycles = 0;
		stable = 0;
		last_l = audio_l;
		last_r = audio_r;
		while ((cycles < HOLD_CYCLES || stable < STABLE_CYCLES) && cycles < SETTLE_TIMEOUT) begin
			tick();
			cycles++;
			if (audio_l == last_l && audio_r == last_r) begin
				stable++;
			end else begin
				stable = 0;
			end
			last_l = audio_l;
			last_r = audio_r;
		end
		if (cycles >= SETTLE_TIMEOUT) begin
			err_count++;
			$display("Error in %s: outputs did not settle within %0d cycles", label,
				SETTLE_TIMEOUT);
		end
	endtask

	task automatic settle_and_compare(input string label);
		wait_settled(label);
		exp_out  = ref_mix(fmt, att_model, core_l, core_r, host_l, host_r);
		cmp_name = label;
		cmp_en   = 1'b1;
		tick();
		cmp_en   = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		int          m;
		resetd         = 1'b1;
		uio            = '0;
		fmt            = '0;
		core_l         = '0;
		core_r         = '0;
		host_l         = '0;
		host_r         = '0;
		att_model      = ATT_RESET;
		rng_state      = 32'h71299271;
		cmp_en         = 1'b0;
		cmp_name       = "";
		test_name      = "";
		err_count      = 0;
		check_count    = 0;
		test_count     = 0;
		test_err_start = 0;
		repeat (2) tick();
		resetd = 1'b0;

		begin_test("reset");
		settle_and_compare("reset zero");
		fmt.is_signed = 1'b1;
		fmt.mix       = 2'd0;
		randomize_samples();
		settle_and_compare("reset signed");
		end_test();

		begin_test("unsigned crossfeed");
		fmt.is_signed = 1'b0;
		for (m = 0; m < 4; m++) begin
			fmt.mix = mix_t'(m);
			randomize_samples();
			settle_and_compare($sformatf("unsigned mode %0d", m));
		end
		end_test();

		begin_test("volume");
		fmt.is_signed = 1'b1;
		fmt.mix       = 2'd2;
		r = next_rand();
		send_transfer(CMD_VOL_ATT, {12'h000, r[3:0]}, '0, 1);
		randomize_samples();
		settle_and_compare("volume shift");
		send_transfer(CMD_VOL_ATT, {11'h000, 1'b1, r[7:4]}, '0, 1);
		settle_and_compare("volume mute");
		end_test();

		begin_test("ignored commands");
		send_transfer(CMD_VOL_ATT, 16'h0003, '0, 1);
		randomize_samples();
		settle_and_compare("valid command");
		// Wrong command byte, the data word must be dropped
		send_transfer(8'h12, 16'h0008, '0, 1);
		settle_and_compare("other command");
		send_transfer(CMD_VOL_ATT, 16'h0001, 16'h0007, 2);
		settle_and_compare("second word");
		send_transfer(CMD_VOL_ATT, 16'h0000, '0, 1);
		settle_and_compare("new command");
		end_test();

		begin_test("clamp");
		fmt.is_signed = 1'b1;
		fmt.mix       = 2'd3;
		core_l        = 16'h7000;
		core_r        = 16'h7000;
		host_l        = 16'h7000;
		host_r        = 16'h7000;
		settle_and_compare("clamp high");
		core_l = 16'h9000;
		core_r = 16'h9000;
		host_l = 16'h9000;
		host_r = 16'h9000;
		settle_and_compare("clamp low");
		end_test();

		begin_test("glitch");
		fmt.mix = 2'd1;
		randomize_samples();
		settle_and_compare("glitch before");
		// Outputs keep the settled value on every cycle through the glitch
		cmp_name = "glitch hold";
		cmp_en   = 1'b1;
		// One cycle of a different core value on both channels
		core_l = ~core_l;
		core_r = core_r ^ 16'h5a5a;
		tick();
		core_l = ~core_l;
		core_r = core_r ^ 16'h5a5a;
		repeat (HOLD_CYCLES) tick();
		cmp_en = 1'b0;
		settle_and_compare("glitch after");
		end_test();

		$display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
			err_count);
		if (err_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/uio_pkg.sv
hw/audio_pkg.sv
hw/uio_cmd_decoder.sv
hw/audio_channel_mix.sv
hw/audio_mix_top.sv
verification/audio_mix_assert.sv
verification/tb_audio_mix.sv
